// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -I.
TOP       = tb_soc_board
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = run.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides, the simulator status does not
run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/1ps -I. \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bus_controller.sv
`include "soc_config.svh"

module bus_controller (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  soc_pkg::bus_req_t   bus_req,
    output soc_pkg::bus_rsp_t   bus_rsp,
    input  soc_pkg::key_event_t key,
    output logic                tx_push,
    output logic [7:0]          tx_byte,
    input  logic                tx_credit,
    output logic [3:0]          irq_vector,
    input  logic                irq_ack
);
    import soc_pkg::*;

    localparam int RAM_WORDS = `SOC_RAM_WORDS;
    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int DEPTH = `SOC_UART_FIFO_DEPTH;
    localparam int CREDIT_W = $clog2(DEPTH + 1);

    // decode of the current cycle
    region_t          region;
    logic [31:0]      ram_offset;
    logic [IDX_W-1:0] ram_index;

    // read pipeline
    logic             busy_q;
    logic             read_start;
    logic             s1_valid_q;
    region_t          rd_region_q;
    logic [IDX_W-1:0] rd_index_q;
    logic             s2_valid_q;
    logic [31:0]      s2_data_q;
    logic [31:0]      lookup_data;

    logic [31:0] ram_mem [RAM_WORDS];

    // software visible state
    logic [7:0]          last_ascii_q;
    logic [7:0]          last_scan_q;
    logic [CREDIT_W-1:0] credits_q;
    logic                key_irq;

    // ====================
    // address decode
    // ====================

    always_comb begin
        // offset compare also covers a nonzero base
        ram_offset = bus_req.address - `SOC_RAM_BASE;
        ram_index = ram_offset[IDX_W+1:2];
        if (ram_offset < 32'(RAM_WORDS * 4)) begin
            region = region_ram;
        end else if (bus_req.address == `SOC_KEY_ADDR) begin
            region = region_key;
        end else if (bus_req.address == `SOC_UART_DATA) begin
            region = region_uart_data;
        end else if (bus_req.address == `SOC_UART_STATUS) begin
            region = region_uart_status;
        end else begin
            region = region_none;
        end
    end

    // ====================
    // read pipeline
    // ====================

    // busy follows read, so a held read starts only once
    assign read_start = bus_req.read && !busy_q;

    // stage 2 source select, ram read uses the registered index
    always_comb begin
        case (rd_region_q)
            region_ram: lookup_data = ram_mem[rd_index_q];
            region_key: lookup_data = {16'd0, last_scan_q, last_ascii_q};
            region_uart_status: lookup_data = 32'(credits_q);
            // uart data is write only
            default: lookup_data = 32'd0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy_q <= 1'b0;
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            bus_rsp <= '0;
        end else begin
            busy_q <= bus_req.read;
            s1_valid_q <= read_start;
            s2_valid_q <= s1_valid_q;
            // done and data land together, one cycle wide
            bus_rsp.read_done <= s2_valid_q;
            bus_rsp.read_data <= s2_data_q;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (read_start) begin
            rd_region_q <= region;
            rd_index_q <= ram_index;
        end
        s2_data_q <= lookup_data;
    end

    // writes take effect at the strobe edge
    always_ff @(posedge CLOCK_50) begin
        if (bus_req.write && (region == region_ram)) begin
            ram_mem[ram_index] <= bus_req.write_data;
        end
    end

    // ====================
    // uart credits
    // ====================

    // no credit left means the write is dropped
    assign tx_push = bus_req.write && (region == region_uart_data) && (credits_q != '0);
    assign tx_byte = bus_req.write_data[7:0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            credits_q <= CREDIT_W'(DEPTH);
        end else begin
            case ({tx_push, tx_credit})
                2'b10: credits_q <= credits_q - 1'b1;
                2'b01: credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    // ====================
    // key and interrupt
    // ====================

    assign key_irq = key.valid && key.make && (key.ascii != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            last_ascii_q <= '0;
            last_scan_q <= '0;
            irq_vector <= '0;
        end else begin
            // releases leave the key register alone
            if (key.valid && key.make) begin
                last_ascii_q <= key.ascii;
                last_scan_q <= key.scan;
            end
            // a new key wins over an ack in the same cycle
            if (key_irq) begin
                irq_vector <= `SOC_KEY_IRQ_VECTOR;
            end else if ((irq_vector != '0) && irq_ack) begin
                irq_vector <= '0;
            end
        end
    end

endmodule

// File: files.f
+incdir+.
soc_pkg.sv
ps2_keyboard.sv
uart_tx.sv
bus_controller.sv
soc_board.sv
soc_board_assertions.sv
tb_soc_board.sv

// File: ps2_keyboard.sv
module ps2_keyboard (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 ps2_clk,
    input  logic                 ps2_dat,
    output soc_pkg::key_event_t  key
);
    import soc_pkg::*;

    // two-flop synchronizers, idle lines are high
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;

    // frame assembly
    logic [9:0]  frame_q;
    logic [3:0]  bit_cnt;
    logic [10:0] frame_full;
    logic        frame_ok;
    logic [7:0]  frame_data;
    logic        break_q;
    key_event_t  key_next;

    // set 2 scan codes, letters and digits only
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        logic [7:0] ascii;
        case (code)
            8'h1c: ascii = "a";
            8'h32: ascii = "b";
            8'h21: ascii = "c";
            8'h23: ascii = "d";
            8'h24: ascii = "e";
            8'h2b: ascii = "f";
            8'h34: ascii = "g";
            8'h33: ascii = "h";
            8'h43: ascii = "i";
            8'h3b: ascii = "j";
            8'h42: ascii = "k";
            8'h4b: ascii = "l";
            8'h3a: ascii = "m";
            8'h31: ascii = "n";
            8'h44: ascii = "o";
            8'h4d: ascii = "p";
            8'h15: ascii = "q";
            8'h2d: ascii = "r";
            8'h1b: ascii = "s";
            8'h2c: ascii = "t";
            8'h3c: ascii = "u";
            8'h2a: ascii = "v";
            8'h1d: ascii = "w";
            8'h22: ascii = "x";
            8'h35: ascii = "y";
            8'h1a: ascii = "z";
            8'h45: ascii = "0";
            8'h16: ascii = "1";
            8'h1e: ascii = "2";
            8'h26: ascii = "3";
            8'h25: ascii = "4";
            8'h2e: ascii = "5";
            8'h36: ascii = "6";
            8'h3d: ascii = "7";
            8'h3e: ascii = "8";
            8'h46: ascii = "9";
            default: ascii = 8'h00;
        endcase
        return ascii;
    endfunction

    // ====================
    // line sync
    // ====================

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // data is sampled on the falling ps/2 clock
    assign clk_fall = clk_prev & ~clk_sync[1];

    // ====================
    // frame check
    // ====================

    // bit 0 start, 8:1 data lsb first, 9 odd parity, 10 stop
    assign frame_full = {dat_sync[1], frame_q};
    assign frame_data = frame_full[8:1];
    assign frame_ok = ~frame_full[0] & frame_full[10] & (^frame_full[9:1]);

    always_comb begin
        key_next.valid = 1'b1;
        key_next.scan = frame_data;
        key_next.ascii = scan_to_ascii(frame_data);
        key_next.make = ~break_q;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            frame_q <= '0;
            bit_cnt <= '0;
            break_q <= 1'b0;
            key <= '0;
        end else begin
            key.valid <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    // eleventh bit closes the frame
                    bit_cnt <= '0;
                    if (frame_ok) begin
                        if (frame_data == 8'hf0) begin
                            // release prefix, next code is a break
                            break_q <= 1'b1;
                        end else begin
                            key <= key_next;
                            break_q <= 1'b0;
                        end
                    end
                end else begin
                    frame_q <= {dat_sync[1], frame_q[9:1]};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

endmodule

// File: soc_board.sv
module soc_board (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    // cpu data bus
    input  soc_pkg::bus_req_t bus_req,
    output soc_pkg::bus_rsp_t bus_rsp,
    // board pins
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    output logic              uart_txd,
    // interrupt to the cpu
    output logic [3:0]        irq_vector,
    input  logic              irq_ack
);
    import soc_pkg::*;

    // keyboard to controller
    key_event_t key;

    // controller to transmitter, credit flow
    logic       tx_push;
    logic [7:0] tx_byte;
    logic       tx_credit;

    // ====================
    // blocks
    // ====================

    ps2_keyboard ps2_keyboard_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .key      (key)
    );

    bus_controller bus_controller_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .key        (key),
        .tx_push    (tx_push),
        .tx_byte    (tx_byte),
        .tx_credit  (tx_credit),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    // serial out through the byte fifo
    uart_tx uart_tx_inst (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .tx_push   (tx_push),
        .tx_byte   (tx_byte),
        .tx_credit (tx_credit),
        .uart_txd  (uart_txd)
    );

endmodule

// File: soc_board_assertions.sv
`include "soc_config.svh"

module soc_board_assertions (
    input logic                                        CLOCK_50,
    input logic                                        KEY0,
    input soc_pkg::bus_req_t                           bus_req,
    input soc_pkg::bus_rsp_t                           bus_rsp,
    input logic                                        busy_q,
    input logic                                        tx_push,
    input logic                                        tx_credit,
    input logic [$clog2(`SOC_UART_FIFO_DEPTH + 1)-1:0] credits_q,
    input logic [3:0]                                  irq_vector,
    input logic                                        irq_ack,
    input logic                                        key_irq
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = `SOC_UART_FIFO_DEPTH;

    // first cycle of a held read
    logic read_start;

    // free fifo slots as seen on the push and credit wires
    int credit_model;

    assign read_start = bus_req.read && !busy_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            credit_model <= DEPTH;
        end else begin
            credit_model <= credit_model - int'(tx_push) + int'(tx_credit);
        end
    end

    // ====================
    // bus handshake
    // ====================

    // done registered two edges after the start edge, seen in the third sample
    read_done_after_start: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        read_start |-> ##3 bus_rsp.read_done)
        else $error("read_done missing two cycles after a new read");

    // and never without a read behind it
    read_done_has_start: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_rsp.read_done |-> $past(read_start, 3))
        else $error("read_done without a read started two cycles before");

    read_done_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_rsp.read_done |=> !bus_rsp.read_done)
        else $error("read_done high two cycles running");

    // ====================
    // uart credits
    // ====================

    // unsigned, an underflow wraps above the depth
    credits_in_range: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        32'(credits_q) <= 32'(DEPTH))
        else $error("credit count outside zero to depth");

    push_needs_credit: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        tx_push |-> (credit_model > 0))
        else $error("uart push with no credit left");

    // ====================
    // interrupt
    // ====================

    irq_clears_on_ack: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ((irq_vector != 4'd0) && irq_ack && !key_irq) |=> (irq_vector == 4'd0))
        else $error("irq_vector still set after an acknowledge");

endmodule

// File: soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ====================
// memory map
// ====================

// ram window starts here, one 32-bit word per entry
`define SOC_RAM_BASE 32'h0000_0000
`define SOC_RAM_WORDS 1024

// peripheral registers, one word each
`define SOC_KEY_ADDR 32'h1000_0000
`define SOC_UART_DATA 32'h1000_0004
`define SOC_UART_STATUS 32'h1000_0008

// ====================
// uart
// ====================

// bit time in CLOCK_50 cycles, short for simulation
`define SOC_UART_CLKS_PER_BIT 16

// byte fifo slots, also the credit count after reset
`define SOC_UART_FIFO_DEPTH 4

// ====================
// interrupts
// ====================

// vector raised for a key press with a printable code
`define SOC_KEY_IRQ_VECTOR 4'd1

`endif

// File: soc_pkg.sv
package soc_pkg;

    // ====================
    // cpu data bus
    // ====================

    // one request cycle from the cpu
    // read is held until read_done, write is a single strobe
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] write_data;
        logic        read;
        logic        write;
    } bus_req_t;

    // controller answer
    // read_data only meaningful while read_done is high
    typedef struct packed {
        logic        read_done;
        logic [31:0] read_data;
    } bus_rsp_t;

    // ====================
    // keyboard
    // ====================

    // one decoded key from the ps/2 receiver
    // valid is a single-cycle pulse
    typedef struct packed {
        logic       valid;
        logic [7:0] scan;
        // zero when the scan code has no mapping
        logic [7:0] ascii;
        // cleared for a release (code after F0)
        logic       make;
    } key_event_t;

    // ====================
    // address decode
    // ====================

    // target of a bus cycle
    typedef enum logic [2:0] {
        region_ram,
        region_key,
        region_uart_data,
        region_uart_status,
        region_none
    } region_t;

endpackage

// File: tb_soc_board.sv
`include "soc_config.svh"

module tb_soc_board;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_pkg::*;

    // ====================
    // constants
    // ====================

    localparam int PS2_HALF = 20;
    localparam logic [31:0] SEED = 32'h3b62dc1c;
    localparam int DEPTH = `SOC_UART_FIFO_DEPTH;
    localparam int CLKS = `SOC_UART_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 22 * PS2_HALF;
    localparam int BYTE_CYCLES = 10 * CLKS;

    // rough length of each test in cycles
    localparam int RESET_LEN = 40;
    localparam int RAM_LEN = 64 * 10;
    localparam int KEY_LEN = 4 * (FRAME_CYCLES + 40);
    localparam int RELEASE_LEN = 2 * (FRAME_CYCLES + 40) + 20;
    localparam int IRQ_LEN = FRAME_CYCLES + 120;
    localparam int UART_LEN = 8 * BYTE_CYCLES;
    localparam int UNMAPPED_LEN = BYTE_CYCLES + 100;
    localparam int TIMEOUT = (RESET_LEN + RAM_LEN + KEY_LEN + RELEASE_LEN + IRQ_LEN
                              + UART_LEN + UNMAPPED_LEN) * 3 / 2;

    // keys picked at random for the interrupt test, set 2 codes
    localparam logic [7:0] PICK_SCAN [4] = '{8'h1c, 8'h32, 8'h21, 8'h23};
    localparam logic [7:0] PICK_ASCII [4] = '{8'h61, 8'h62, 8'h63, 8'h64};

    logic       CLOCK_50;
    logic       KEY0;
    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    logic       ps2_clk;
    logic       ps2_dat;
    logic       uart_txd;
    logic [3:0] irq_vector;
    logic       irq_ack;

    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          cycle_count;

    // reference models
    logic [31:0] ram_model [`SOC_RAM_WORDS];
    logic [31:0] ram_addrs [$];
    logic [7:0]  uart_expected [$];
    logic [7:0]  uart_received [$];

    soc_board soc_board_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .uart_txd   (uart_txd),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    // protocol checks inside the controller
    bind bus_controller soc_board_assertions assertions_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .busy_q     (busy_q),
        .tx_push    (tx_push),
        .tx_credit  (tx_credit),
        .credits_q  (credits_q),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack),
        .key_irq    (key_irq)
    );

    initial CLOCK_50 = 1'b0;
    always #5 CLOCK_50 = ~CLOCK_50;

    // run limit
    always @(posedge CLOCK_50) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ====================
    // helpers
    // ====================

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr - `SOC_RAM_BASE) >> 2);
    endfunction

    function automatic void report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s done, %0d errors", name, errors - errors_before);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge CLOCK_50);
        bus_req.address <= addr;
        bus_req.write_data <= data;
        bus_req.write <= 1'b1;
        // single strobe
        @(posedge CLOCK_50);
        bus_req.write <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int waited;
        data = 32'd0;
        @(posedge CLOCK_50);
        bus_req.address <= addr;
        bus_req.read <= 1'b1;
        @(negedge CLOCK_50);
        waited = 1;
        while (!bus_rsp.read_done && waited < 16) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (bus_rsp.read_done) begin
            data = bus_rsp.read_data;
            // sampled at the next edge, then 2 cycles, so seen at the 4th falling edge
            checks++;
            assert (waited == 4) else
                report_failure($sformatf("read_done seen at falling edge %0d instead of 4",
                                         waited));
        end else begin
            report_failure($sformatf("no read_done for address 0x%08h", addr));
        end
        // drop read the cycle after done
        @(posedge CLOCK_50);
        bus_req.read <= 1'b0;
    endtask

    task automatic send_ps2_byte(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        // stop, odd parity, data lsb first, start
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge CLOCK_50);
            ps2_dat <= frame[i];
            repeat (PS2_HALF) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            repeat (PS2_HALF) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
        end
        // key event is 3 cycles after the last fall, long gone by now
        repeat (4) @(posedge CLOCK_50);
    endtask

    task automatic check_key_register(input logic [7:0] ascii);
        logic [31:0] data;
        bus_read(`SOC_KEY_ADDR, data);
        check_value("key ascii", {24'd0, data[7:0]}, {24'd0, ascii});
    endtask

    task automatic ack_irq();
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    // ====================
    // uart line sampler
    // ====================

    initial begin : uart_line_sampler
        logic [7:0] rx_byte;
        @(posedge KEY0);
        forever begin
            @(negedge CLOCK_50);
            if (uart_txd == 1'b0) begin
                // to the middle of the start bit
                repeat (CLKS / 2) @(negedge CLOCK_50);
                if (uart_txd !== 1'b0) begin
                    report_failure("uart start bit shorter than half a bit");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge CLOCK_50);
                    rx_byte[i] = uart_txd;
                end
                repeat (CLKS) @(negedge CLOCK_50);
                if (uart_txd !== 1'b1) begin
                    report_failure("uart stop bit was low");
                end
                uart_received.push_back(rx_byte);
            end
        end
    end

    // ====================
    // tests
    // ====================

    task automatic after_reset();
        int errors_before;
        logic [31:0] data;
        errors_before = errors;
        @(negedge CLOCK_50);
        check_value("read_done", {31'd0, bus_rsp.read_done}, 32'd0);
        check_value("irq_vector", {28'd0, irq_vector}, 32'd0);
        check_value("uart_txd", {31'd0, uart_txd}, 32'd1);
        bus_read(`SOC_UART_STATUS, data);
        check_value("uart status", data, 32'(DEPTH));
        report_test("after reset", errors_before);
    endtask

    task automatic ram_readback();
        int errors_before;
        logic [31:0] addr;
        logic [31:0] data;
        errors_before = errors;
        for (int i = 0; i < 32; i++) begin
            addr = `SOC_RAM_BASE + ((next_rand() % 32'(`SOC_RAM_WORDS)) << 2);
            data = next_rand();
            bus_write(addr, data);
            ram_model[word_index(addr)] = data;
            ram_addrs.push_back(addr);
        end
        foreach (ram_addrs[i]) begin
            bus_read(ram_addrs[i], data);
            check_value("read_data", data, ram_model[word_index(ram_addrs[i])]);
        end
        report_test("ram readback", errors_before);
    endtask

    task automatic key_register();
        int errors_before;
        errors_before = errors;
        send_ps2_byte(8'h1c, 1'b0);
        check_key_register(8'h61);
        send_ps2_byte(8'h32, 1'b0);
        check_key_register(8'h62);
        send_ps2_byte(8'h16, 1'b0);
        check_key_register(8'h31);
        // bad parity, frame dropped
        send_ps2_byte(8'h21, 1'b1);
        check_key_register(8'h31);
        report_test("key register", errors_before);
    endtask

    task automatic key_release();
        int errors_before;
        errors_before = errors;
        // pending key interrupt cleared first
        ack_irq();
        check_value("irq_vector", {28'd0, irq_vector}, 32'd0);
        send_ps2_byte(8'hf0, 1'b0);
        send_ps2_byte(8'h1b, 1'b0);
        check_key_register(8'h31);
        @(negedge CLOCK_50);
        check_value("irq_vector", {28'd0, irq_vector}, 32'd0);
        report_test("key release", errors_before);
    endtask

    task automatic key_interrupt();
        int errors_before;
        int pick;
        errors_before = errors;
        pick = int'(next_rand() % 32'd4);
        send_ps2_byte(PICK_SCAN[pick], 1'b0);
        @(negedge CLOCK_50);
        check_value("irq_vector", {28'd0, irq_vector}, {28'd0, `SOC_KEY_IRQ_VECTOR});
        // held without an ack
        repeat (20) @(posedge CLOCK_50);
        check_key_register(PICK_ASCII[pick]);
        @(negedge CLOCK_50);
        check_value("irq_vector", {28'd0, irq_vector}, {28'd0, `SOC_KEY_IRQ_VECTOR});
        ack_irq();
        check_value("irq_vector", {28'd0, irq_vector}, 32'd0);
        report_test("key interrupt", errors_before);
    endtask

    task automatic uart_credit_flow();
        int errors_before;
        int credits;
        int waited;
        logic [31:0] data;
        logic [31:0] status;
        errors_before = errors;
        // first byte keeps the serializer busy through the burst, credit comes back at once
        data = next_rand();
        bus_write(`SOC_UART_DATA, data);
        uart_expected.push_back(data[7:0]);
        bus_read(`SOC_UART_STATUS, status);
        check_value("uart status", status, 32'(DEPTH));
        // no pop while busy, so only DEPTH of 6 fit
        credits = DEPTH;
        for (int i = 0; i < 6; i++) begin
            data = next_rand();
            bus_write(`SOC_UART_DATA, data);
            if (credits > 0) begin
                uart_expected.push_back(data[7:0]);
                credits--;
            end
            bus_read(`SOC_UART_STATUS, status);
            check_value("uart status", status, 32'(credits));
        end
        waited = 0;
        while (uart_received.size() < uart_expected.size() && waited < 6 * BYTE_CYCLES) begin
            @(posedge CLOCK_50);
            waited++;
        end
        // room for a stray extra byte to show up
        repeat (BYTE_CYCLES) @(posedge CLOCK_50);
        checks++;
        assert (uart_received.size() == uart_expected.size()) else
            report_failure($sformatf("uart line carried %0d bytes instead of %0d",
                                     uart_received.size(), uart_expected.size()));
        foreach (uart_expected[i]) begin
            if (i < uart_received.size()) begin
                check_value("uart byte", {24'd0, uart_received[i]}, {24'd0, uart_expected[i]});
            end
        end
        @(negedge CLOCK_50);
        check_value("uart_txd", {31'd0, uart_txd}, 32'd1);
        bus_read(`SOC_UART_STATUS, status);
        check_value("uart status", status, 32'(DEPTH));
        report_test("uart credit flow", errors_before);
    endtask

    task automatic unmapped_access();
        int errors_before;
        int sent_before;
        logic [31:0] data;
        errors_before = errors;
        sent_before = uart_received.size();
        bus_read(32'h2000_0000, data);
        check_value("read_data", data, 32'd0);
        // aliases of a ram word and a slot next to the uart
        bus_write(32'h2000_0000 | ram_addrs[0], ~ram_model[word_index(ram_addrs[0])]);
        bus_write(32'h1000_000c, 32'h0000_0055);
        bus_read(ram_addrs[0], data);
        check_value("read_data", data, ram_model[word_index(ram_addrs[0])]);
        bus_read(`SOC_UART_STATUS, data);
        check_value("uart status", data, 32'(DEPTH));
        repeat (BYTE_CYCLES + 20) @(posedge CLOCK_50);
        check_value("uart bytes sent", 32'(uart_received.size()), 32'(sent_before));
        report_test("unmapped access", errors_before);
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin : main
        lcg_state = SEED;
        checks = 0;
        errors = 0;
        cycle_count = 0;
        KEY0 = 1'b0;
        bus_req = '0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        irq_ack = 1'b0;
        repeat (3) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        after_reset();
        ram_readback();
        key_register();
        key_release();
        key_interrupt();
        uart_credit_flow();
        unmapped_access();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: uart_tx.sv
`include "soc_config.svh"

module uart_tx (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       tx_push,
    input  logic [7:0] tx_byte,
    output logic       tx_credit,
    output logic       uart_txd
);

    localparam int DEPTH = `SOC_UART_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CLKS = `SOC_UART_CLKS_PER_BIT;
    localparam int TICK_W = $clog2(CLKS);

    // ====================
    // byte fifo
    // ====================

    logic [7:0]       fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop;

    // serializer state
    logic              busy;
    logic [TICK_W-1:0] tick;
    logic [3:0]        bit_idx;
    logic [9:0]        shift_q;
    logic              last_tick;

    // credits keep the fifo from overflowing, full check is a guard only
    assign push_ok = tx_push && (count != CNT_W'(DEPTH));

    // end of the stop bit, next byte may start right away
    assign last_tick = busy && (tick == TICK_W'(CLKS - 1)) && (bit_idx == 4'd9);
    assign pop = (!busy || last_tick) && (count != '0);

    // one credit back per byte leaving the fifo
    assign tx_credit = pop;

    always_ff @(posedge CLOCK_50) begin
        if (push_ok) begin
            fifo_mem[wr_ptr] <= tx_byte;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ====================
    // 8n1 serializer
    // ====================

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy <= 1'b0;
            tick <= '0;
            bit_idx <= '0;
            // all ones keeps the line idle
            shift_q <= '1;
        end else if (pop) begin
            // stop, data lsb first, start in bit 0
            shift_q <= {1'b1, fifo_mem[rd_ptr], 1'b0};
            busy <= 1'b1;
            tick <= '0;
            bit_idx <= '0;
        end else if (busy) begin
            if (tick == TICK_W'(CLKS - 1)) begin
                tick <= '0;
                shift_q <= {1'b1, shift_q[9:1]};
                if (bit_idx == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    assign uart_txd = shift_q[0];

endmodule
